// ==== Bender.yml ====
package:
  name: adc_slice

sources:
  - hdl/adc_slice_pkg.sv
  - hdl/tdc_sample_if.sv
  - hdl/slice_timing.sv
  - hdl/tdc_capture.sv
  - hdl/wallace_adder.sv
  - hdl/phase_monitor.sv
  - hdl/adc_slice_top.sv
  - target: simulation
    files:
      - testbench/tb_adc_slice_checks.sv
      - testbench/tb_adc_slice.sv

// ==== flist.f ====
hdl/adc_slice_pkg.sv
hdl/tdc_sample_if.sv
hdl/slice_timing.sv
hdl/tdc_capture.sv
hdl/wallace_adder.sv
hdl/phase_monitor.sv
hdl/adc_slice_top.sv
testbench/tb_adc_slice_checks.sv
testbench/tb_adc_slice.sv

// ==== hdl/adc_slice_pkg.sv ====
package adc_slice_pkg;

    // Output code width and number of delay-chain flip-flops.
    localparam int NADC = 8;
    localparam int NTHM = (2 ** NADC) - 1;

    // Phase-monitor result width.
    localparam int PM_W = 20;

    typedef logic [NTHM-1:0] therm_t;
    typedef logic [NADC-1:0] adc_code_t;
    typedef logic [PM_W-1:0] pm_count_t;

    // Bit 1 picks the reference, bit 0 the measured input.
    typedef enum logic [1:0] {
        PH_STROBE_EXT = 2'b00,
        PH_STROBE_DEL = 2'b01,
        PH_SIGN_EXT   = 2'b10,
        PH_SIGN_DEL   = 2'b11
    } ph_src_e;

endpackage

// ==== hdl/adc_slice_top.sv ====
`timescale 1ns/1ps

module adc_slice_top import adc_slice_pkg::*; #(
    parameter int NDIV           = 2,
    parameter int PM_WINDOW_LOG2 = 10
) (
    input  logic            clk_adder,
    input  logic            rstb,
    input  logic            en_slice,
    input  logic            en_sync_in,
    input  logic            alws_on,
    input  logic [NDIV-1:0] init,
    input  therm_t          ff_in,
    input  logic            sign_in,
    input  logic            en_tdc_phase_reverse,
    input  logic            ph_ext,
    input  logic            en_pm,
    input  logic [1:0]      sel_pm_sign,
    input  ph_src_e         sel_pm_in,
    output logic            en_sync_out,
    output logic            del_out,
    output adc_code_t       adder_out,
    output logic            sign_out,
    output logic            adder_valid,
    output pm_count_t       pm_out,
    output logic            pm_valid
);

    logic strobe;

    tdc_sample_if sample_if ();

    slice_timing #(
        .NDIV(NDIV)
    ) i_slice_timing (
        .clk_adder  (clk_adder),
        .rstb       (rstb),
        .en_slice   (en_slice),
        .en_sync_in (en_sync_in),
        .alws_on    (alws_on),
        .init       (init),
        .strobe     (strobe),
        .en_sync_out(en_sync_out)
    );

    tdc_capture i_tdc_capture (
        .clk_adder           (clk_adder),
        .rstb                (rstb),
        .strobe              (strobe),
        .ff_in               (ff_in),
        .sign_in             (sign_in),
        .en_tdc_phase_reverse(en_tdc_phase_reverse),
        .del_out             (del_out),
        .sample              (sample_if.capture)
    );

    wallace_adder i_wallace_adder (
        .clk_adder  (clk_adder),
        .rstb       (rstb),
        .sample     (sample_if.adder),
        .adder_out  (adder_out),
        .sign_out   (sign_out),
        .adder_valid(adder_valid)
    );

    // Monitor sees the strobe, chain output and raw sign.
    phase_monitor #(
        .PM_WINDOW_LOG2(PM_WINDOW_LOG2)
    ) i_phase_monitor (
        .clk_adder  (clk_adder),
        .rstb       (rstb),
        .en_pm      (en_pm),
        .sel_pm_in  (sel_pm_in),
        .sel_pm_sign(sel_pm_sign),
        .ph_ext     (ph_ext),
        .del_out    (del_out),
        .sign_in    (sign_in),
        .strobe     (strobe),
        .pm_out     (pm_out),
        .pm_valid   (pm_valid)
    );

endmodule

// ==== hdl/phase_monitor.sv ====
`timescale 1ns/1ps

module phase_monitor import adc_slice_pkg::*; #(
    parameter int PM_WINDOW_LOG2 = 10
) (
    input  logic       clk_adder,
    input  logic       rstb,
    input  logic       en_pm,
    input  ph_src_e    sel_pm_in,
    input  logic [1:0] sel_pm_sign,
    input  logic       ph_ext,
    input  logic       del_out,
    input  logic       sign_in,
    input  logic       strobe,
    output pm_count_t  pm_out,
    output logic       pm_valid
);

    logic [PM_WINDOW_LOG2-1:0] win_cnt;
    pm_count_t                 mis_cnt;
    pm_count_t                 mis_next;
    logic                      ph_ref;
    logic                      ph_in;
    logic                      mismatch;
    logic                      win_last;

    // Source muxes, then polarity adjust on each side.
    always_comb begin
        ph_ref   = sel_pm_in[1] ? sign_in : strobe;
        ph_in    = sel_pm_in[0] ? del_out : ph_ext;
        mismatch = (ph_in ^ sel_pm_sign[0]) != (ph_ref ^ sel_pm_sign[1]);
        mis_next = mis_cnt + mismatch;
        win_last = &win_cnt;
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            win_cnt  <= '0;
            mis_cnt  <= '0;
            pm_out   <= '0;
            pm_valid <= 1'b0;
        end else if (!en_pm) begin
            win_cnt  <= '0;
            mis_cnt  <= '0;
            pm_valid <= 1'b0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            if (win_last) begin
                // Last cycle of the window is counted too.
                pm_out   <= mis_next;
                pm_valid <= 1'b1;
                mis_cnt  <= '0;
            end else begin
                pm_valid <= 1'b0;
                mis_cnt  <= mis_next;
            end
        end
    end

    a_pm_valid_pulse: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        pm_valid |=> !pm_valid
    );

endmodule

// ==== hdl/slice_timing.sv ====
`timescale 1ns/1ps

module slice_timing #(
    parameter int NDIV = 2
) (
    input  logic            clk_adder,
    input  logic            rstb,
    input  logic            en_slice,
    input  logic            en_sync_in,
    input  logic            alws_on,
    input  logic [NDIV-1:0] init,
    output logic            strobe,
    output logic            en_sync_out
);

    logic [NDIV-1:0] div_cnt;

    // Divider phase is loaded from init until the sync enable arrives.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            div_cnt <= '0;
        end else if (!en_sync_in) begin
            div_cnt <= init;
        end else if (en_slice) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Sync enable is passed on to the next slice one cycle later.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_sync_out <= 1'b0;
        end else begin
            en_sync_out <= en_sync_in;
        end
    end

    // One strobe per divider period, or every cycle when always-on.
    always_comb begin
        strobe = en_slice & (alws_on | (en_sync_in & (&div_cnt)));
    end

    a_no_strobe_disabled: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        !en_slice |-> !strobe
    );

endmodule

// ==== hdl/tdc_capture.sv ====
`timescale 1ns/1ps

module tdc_capture import adc_slice_pkg::*; (
    input  logic                 clk_adder,
    input  logic                 rstb,
    input  logic                 strobe,
    input  therm_t               ff_in,
    input  logic                 sign_in,
    input  logic                 en_tdc_phase_reverse,
    output logic                 del_out,
    tdc_sample_if.capture        sample
);

    logic   rev_meta;
    logic   rev_sync;
    therm_t therm_next;

    // Two-stage synchronizer on the phase-reverse control.
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            rev_meta <= 1'b0;
            rev_sync <= 1'b0;
        end else begin
            rev_meta <= en_tdc_phase_reverse;
            rev_sync <= rev_meta;
        end
    end

    // Reversed phase flips every chain bit.
    always_comb begin
        therm_next = rev_sync ? ~ff_in : ff_in;
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            sample.valid <= 1'b0;
            del_out      <= 1'b0;
        end else begin
            sample.valid <= strobe;
            if (strobe) begin
                del_out <= therm_next[NTHM-1];
            end
        end
    end

    // Sample payload.
    always_ff @(posedge clk_adder) begin
        if (strobe) begin
            sample.therm <= therm_next;
            sample.sign  <= sign_in;
            sample.rev   <= rev_sync;
        end
    end

    a_valid_after_strobe: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        $rose(sample.valid) |-> $past(strobe)
    );

    // Reverse flag on a sample lags the control by the synchronizer.
    a_rev_latency: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        sample.valid |-> sample.rev == $past(en_tdc_phase_reverse, 3)
    );

endmodule

// ==== hdl/tdc_sample_if.sv ====
`timescale 1ns/1ps

interface tdc_sample_if import adc_slice_pkg::*; ();

    logic   valid;
    therm_t therm;
    logic   sign;
    logic   rev;

    // Capture side drives a sample for one cycle.
    modport capture (
        output valid,
        output therm,
        output sign,
        output rev
    );

    // Adder takes every sample, no back-pressure.
    modport adder (
        input valid,
        input therm,
        input sign,
        input rev
    );

endinterface

// ==== hdl/wallace_adder.sv ====
`timescale 1ns/1ps

module wallace_adder import adc_slice_pkg::*; (
    input  logic          clk_adder,
    input  logic          rstb,
    tdc_sample_if.adder   sample,
    output adc_code_t     adder_out,
    output logic          sign_out,
    output logic          adder_valid
);

    localparam int GRP_W = 16;
    localparam int NGRP  = (NTHM + 1) / GRP_W;

    typedef logic [4:0] grp_sum_t;

    logic [NTHM:0] therm_pad;
    grp_sum_t      grp_next [NGRP];
    grp_sum_t      grp_sum  [NGRP];
    logic          s1_sign;
    logic          s1_valid;
    adc_code_t     total_next;

    // Sixteen-bit count as a balanced tree of pairwise adds.
    function automatic grp_sum_t pop16(input logic [GRP_W-1:0] b);
        logic [1:0] l1 [8];
        logic [2:0] l2 [4];
        logic [3:0] l3 [2];
        for (int i = 0; i < 8; i++) begin
            l1[i] = b[2*i] + b[2*i+1];
        end
        for (int i = 0; i < 4; i++) begin
            l2[i] = l1[2*i] + l1[2*i+1];
        end
        for (int i = 0; i < 2; i++) begin
            l3[i] = l2[2*i] + l2[2*i+1];
        end
        return l3[0] + l3[1];
    endfunction

    // Top pad bit is zero so the code splits into even groups.
    always_comb begin
        therm_pad = {1'b0, sample.therm};
        for (int g = 0; g < NGRP; g++) begin
            grp_next[g] = pop16(therm_pad[g*GRP_W +: GRP_W]);
        end
    end

    always_comb begin
        total_next = '0;
        for (int g = 0; g < NGRP; g++) begin
            total_next = total_next + grp_sum[g];
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            s1_valid    <= 1'b0;
            adder_valid <= 1'b0;
        end else begin
            s1_valid    <= sample.valid;
            adder_valid <= s1_valid;
        end
    end

    // Stage 1 group sums, stage 2 total.
    always_ff @(posedge clk_adder) begin
        grp_sum   <= grp_next;
        s1_sign   <= sample.sign;
        adder_out <= total_next;
        sign_out  <= s1_sign;
    end

    a_valid_latency: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        sample.valid |-> ##2 adder_valid
    );

endmodule

// ==== testbench/tb_adc_slice.sv ====
`timescale 1ns/1ps

module tb_adc_slice import adc_slice_pkg::*; ();

    localparam int NDIV     = 2;
    localparam int PM_LOG2  = 6;
    localparam int CLK_PER  = 40;
    localparam int PH1_CYC  = 80;
    localparam int PH2_CYC  = 100;
    localparam int PH3_CYC  = 4 * (2 ** PM_LOG2) + 8;
    localparam int TIMEOUT  = (3 + PH1_CYC + PH2_CYC + PH3_CYC) * CLK_PER + 4000;

    logic            clk_adder;
    logic            rstb;
    logic            en_slice;
    logic            en_sync_in;
    logic            alws_on;
    logic [NDIV-1:0] init;
    therm_t          ff_in;
    logic            sign_in;
    logic            en_tdc_phase_reverse;
    logic            ph_ext;
    logic            en_pm;
    logic [1:0]      sel_pm_sign;
    ph_src_e         sel_pm_in;
    logic            en_sync_out;
    logic            del_out;
    adc_code_t       adder_out;
    logic            sign_out;
    logic            adder_valid;
    pm_count_t       pm_out;
    logic            pm_valid;

    int   exp_period;
    logic pm_strobe_ref;
    logic ph_rand_en;
    logic check_failed;

    adc_slice_top #(
        .NDIV          (NDIV),
        .PM_WINDOW_LOG2(PM_LOG2)
    ) i_dut (.*);

    tb_adc_slice_checks #(
        .NDIV   (NDIV),
        .PM_LOG2(PM_LOG2)
    ) i_checks (.*);

    initial begin
        clk_adder = 1'b0;
        forever #(CLK_PER / 2) clk_adder = ~clk_adder;
    end

    // Fresh chain state and sign every cycle.
    always @(posedge clk_adder) begin
        logic [255:0] bits;
        bits = {$urandom(), $urandom(), $urandom(), $urandom(),
                $urandom(), $urandom(), $urandom(), $urandom()};
        ff_in   <= bits[NTHM-1:0];
        sign_in <= $urandom() & 1;
        ph_ext  <= ph_rand_en ? ($urandom() & 1) : 1'b0;
    end

    task automatic wait_pm_windows(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk_adder);
            if (pm_valid) begin
                seen++;
            end
        end
    endtask

    initial begin
        void'($urandom(52639));
        rstb = 1'b0;
        en_slice = 1'b0;
        en_sync_in = 1'b0;
        alws_on = 1'b0;
        init = '0;
        ff_in = '0;
        sign_in = 1'b0;
        en_tdc_phase_reverse = 1'b0;
        ph_ext = 1'b0;
        en_pm = 1'b0;
        sel_pm_sign = 2'b00;
        sel_pm_in = PH_SIGN_EXT;
        exp_period = 0;
        pm_strobe_ref = 1'b0;
        ph_rand_en = 1'b1;
        repeat (3) @(posedge clk_adder);
        rstb <= 1'b1;

        // Divided sampling, started by the sync enable.
        repeat (4) @(posedge clk_adder);
        en_slice <= 1'b1;
        init <= $urandom();
        repeat (3) @(posedge clk_adder);
        en_sync_in <= 1'b1;
        repeat (10) @(posedge clk_adder);
        exp_period <= 2 ** NDIV;
        repeat (PH1_CYC - 17) @(posedge clk_adder);

        // Always-on sampling with phase reverse toggles.
        exp_period <= 0;
        alws_on <= 1'b1;
        repeat (8) @(posedge clk_adder);
        exp_period <= 1;
        for (int i = 0; i < 4; i++) begin
            repeat ((PH2_CYC - 8) / 4) @(posedge clk_adder);
            en_tdc_phase_reverse <= ~en_tdc_phase_reverse;
        end
        exp_period <= 0;
        alws_on <= 1'b0;
        en_tdc_phase_reverse <= 1'b0;
        repeat (6) @(posedge clk_adder);

        // Monitor with sign against ph_ext, then strobe as reference.
        sel_pm_sign <= $urandom();
        en_pm <= 1'b1;
        wait_pm_windows(2);
        en_pm <= 1'b0;
        pm_strobe_ref <= 1'b1;
        ph_rand_en <= 1'b0;
        sel_pm_in <= PH_STROBE_EXT;
        sel_pm_sign <= $urandom();
        @(posedge clk_adder);
        en_pm <= 1'b1;
        wait_pm_windows(2);
        repeat (2) @(posedge clk_adder);

        if (check_failed) begin
            $display("Result: FAILED");
            $fatal(1, "Run ended with a failed check");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    initial begin
        wait (check_failed === 1'b1);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first failed check");
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before the test sequence completed");
        $display("Result: FAILED");
        $fatal(1, "Timeout");
    end

endmodule

// ==== testbench/tb_adc_slice_checks.sv ====
`timescale 1ns/1ps

module tb_adc_slice_checks import adc_slice_pkg::*; #(
    parameter int NDIV    = 2,
    parameter int PM_LOG2 = 6
) (
    input  logic       clk_adder,
    input  logic       rstb,
    input  logic       en_slice,
    input  logic       en_sync_in,
    input  therm_t     ff_in,
    input  logic       sign_in,
    input  logic       en_tdc_phase_reverse,
    input  logic       ph_ext,
    input  logic       en_pm,
    input  logic [1:0] sel_pm_sign,
    input  logic       en_sync_out,
    input  logic       del_out,
    input  adc_code_t  adder_out,
    input  logic       sign_out,
    input  logic       adder_valid,
    input  pm_count_t  pm_out,
    input  logic       pm_valid,
    input  int         exp_period,
    input  logic       pm_strobe_ref,
    output logic       check_failed
);

    localparam int WIN = 2 ** PM_LOG2;

    adc_code_t pc_hist [3];
    logic [2:0] sign_hist = '0;
    logic [7:0] rev_hist = '0;
    logic       sync_prev = 1'b0;
    logic       en_seen = 1'b0;
    int         gap = 0;
    int         win_n = 0;
    int         mis_acc = 0;
    int         win_result = 0;
    logic       rev_stable;
    adc_code_t  exp_code;
    int         pm_exp;
    int         strobes;

    initial check_failed = 1'b0;

    task automatic report_mismatch(input string name, input int exp_v, input int act_v);
        $display("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v);
        check_failed = 1'b1;
    endtask

    always @(posedge clk_adder) begin
        pc_hist   <= '{$countones(ff_in), pc_hist[0], pc_hist[1]};
        sign_hist <= {sign_hist[1:0], sign_in};
        rev_hist  <= {rev_hist[6:0], en_tdc_phase_reverse};
        sync_prev <= en_sync_in;
        en_seen   <= en_seen | en_slice;
        gap       <= adder_valid ? 1 : gap + 1;
    end

    // Window model of the monitor for the sign and ph_ext pairing.
    always @(posedge clk_adder) begin
        int mis;
        mis = ((ph_ext ^ sel_pm_sign[0]) != (sign_in ^ sel_pm_sign[1])) ? 1 : 0;
        if (!en_pm) begin
            win_n   <= 0;
            mis_acc <= 0;
        end else if (win_n == WIN - 1) begin
            win_result <= mis_acc + mis;
            win_n      <= 0;
            mis_acc    <= 0;
        end else begin
            win_n   <= win_n + 1;
            mis_acc <= mis_acc + mis;
        end
    end

    // Sample reaching the output was captured with the control from 5 edges back.
    always_comb begin
        rev_stable = (rev_hist == 8'h00) || (rev_hist == 8'hff);
        exp_code   = rev_hist[4] ? adc_code_t'(NTHM - pc_hist[2]) : pc_hist[2];
        strobes    = WIN / (2 ** NDIV);
        pm_exp     = pm_strobe_ref ? ((^sel_pm_sign) ? WIN - strobes : strobes) : win_result;
    end

    a_sync_chain: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        en_sync_out == sync_prev
    ) else report_mismatch("sync_chain", $sampled(sync_prev), $sampled(en_sync_out));

    a_spacing: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        (adder_valid && exp_period != 0) |-> gap == exp_period
    ) else report_mismatch("sample_spacing", $sampled(exp_period), $sampled(gap));

    a_popcount: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        (adder_valid && rev_stable) |-> adder_out == exp_code
    ) else report_mismatch("popcount", $sampled(exp_code), $sampled(adder_out));

    a_sign: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        adder_valid |-> sign_out == sign_hist[2]
    ) else report_mismatch("sign", $sampled(sign_hist[2]), $sampled(sign_out));

    a_phase_monitor: assert property (
        @(posedge clk_adder) disable iff (!rstb)
        pm_valid |-> pm_out == pm_exp
    ) else report_mismatch("phase_monitor", $sampled(pm_exp), $sampled(pm_out));

    // Outputs stay idle through reset and until the slice is enabled.
    a_reset_state: assert property (
        @(posedge clk_adder)
        !en_seen |-> (!adder_valid && !pm_valid && pm_out == '0 && !del_out)
    ) else begin
        $display("Outputs were not idle during reset or before the first capture");
        check_failed = 1'b1;
    end

endmodule
